// File: Makefile
# Verilator build and run of the tag cache testbench
TOP := tb_cap_tag

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f cap_tag.f -Mdir obj_dir -o $(TOP)
	out="$$(./obj_dir/$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

// File: cap_tag.f
logic/cap_tag_pkg.sv
logic/tag_region_map.sv
logic/tag_line_ram.sv
logic/cap_cache.sv
logic/cap_tag_top.sv
sim/cap_tag_props.sv
sim/tb_cap_tag.sv

// File: logic/cap_cache.sv
// direct mapped write back tag cache controller
// holds the tag, valid and modified arrays and moves lines over a single beat bus
// one access in flight, accepted on access while ready is high, finished by done

`timescale 1ns/1ps

module cap_cache #(
	parameter int DEP = 16,
	parameter logic [cap_tag_pkg::ADDR_W-1:0] DRAM_TAG_BASE = 32'h3FE0_0000,
	parameter logic [cap_tag_pkg::ADDR_W-1:0] ROM_TAG_BASE  = 32'hFFF9_F800
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     access,	// one cycle strobe
	input  cap_tag_pkg::tag_access_t acc,
	output logic                     ready,
	output logic                     done,	// one cycle, hit and tago valid with it
	output logic                     hit,
	output logic                     tago,
	output cap_tag_pkg::bus_req_t    req,
	input  cap_tag_pkg::bus_resp_t   resp
);

	import cap_tag_pkg::*;

	localparam int IW    = $clog2(DEP);	// index bits start at address bit 11
	localparam int TAG_W = ADDR_W - 11 - IW;	// address tag is everything above the index

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		DUMP,
		DUMP_ACK,
		LOAD,
		LOAD_ACK
	} state_e;

	// ========================================
	// state and line bookkeeping
	// ========================================

	state_e            state;
	logic              pend;	// set after a load so idle re-runs the held access
	logic              missed;	// the access in flight took a miss, reported at done
	logic [DEP-1:0]    v;	// line valid
	logic [DEP-1:0]    m;	// line modified, never set for rom lines
	logic [TAG_W-1:0]  tag_arr [DEP];

	tag_access_t       acc_r;	// access being worked on
	tag_access_t       cur;	// access seen by the lookup in idle
	logic              hit_r;	// hit result of the last lookup
	region_e           reg_r;	// region of the held access
	logic [ADDR_W-1:0] load_adr;	// tag area address of the missing line
	logic [ADDR_W-1:0] vic_adr;	// tag area address of the line being evicted

	logic              req_cyc;
	logic              req_we;
	logic [ADDR_W-1:0] req_adr;
	logic [LINE_W-1:0] req_dat;

	logic [IW-1:0]     cur_idx;
	logic [TAG_W-1:0]  cur_tag;
	logic [IW-1:0]     idx_r;
	logic [ADDR_W-1:0] map_in;
	region_e           map_region;
	logic [ADDR_W-1:0] map_line;
	logic              launch;	// a lookup starts this cycle
	logic              ihit;

	logic [IW-1:0]     ram_ra;
	logic [LINE_W-1:0] ram_rd;
	logic              ram_we;
	logic [LINE_W-1:0] ram_wd;
	logic              upd_wr;	// hit on a dram write or tag store
	logic              new_bit;
	logic [LINE_W-1:0] merged;

	assign ready   = (state == IDLE) && !pend;	// high again in the cycle done rises
	assign cur     = pend ? acc_r : acc;	// a pending re-run has priority over the port
	assign cur_idx = cur.adr[11 +: IW];
	assign cur_tag = cur.adr[ADDR_W-1 -: TAG_W];
	assign idx_r   = acc_r.adr[11 +: IW];
	assign launch  = (state == IDLE) && (pend || access);

	// idle maps the new access, the other states map the line sitting at its index
	assign map_in = (state == IDLE) ? cur.adr : {tag_arr[idx_r], idx_r, 11'd0};

	tag_region_map #(
		.DRAM_TAG_BASE(DRAM_TAG_BASE),
		.ROM_TAG_BASE (ROM_TAG_BASE)
	) u_tag_region_map (
		.adr     (map_in),
		.region  (map_region),
		.line_adr(map_line)
	);

	// i/o always hits, otherwise a valid line with a matching tag
	assign ihit = (map_region == REG_IO) || (v[cur_idx] && tag_arr[cur_idx] == cur_tag);

	// ========================================
	// line RAM and bit update
	// ========================================

	assign ram_ra = (state == IDLE) ? cur_idx : idx_r;	// read launched together with the hit test

	// rom and i/o lines are never changed
	assign upd_wr  = (state == LOOKUP) && hit_r && (reg_r == REG_DRAM) && (acc_r.op != OP_READ);
	assign new_bit = (acc_r.op == OP_TAG_STORE) ? acc_r.tagi : 1'b0;	// plain writes clear it

	always_comb begin
		merged = ram_rd;
		merged[acc_r.adr[10:3]] = new_bit;	// bits 10:3 pick the word within the line
	end

	assign ram_we = upd_wr || ((state == LOAD_ACK) && resp.ack);
	assign ram_wd = (state == LOAD_ACK) ? resp.dat : merged;

	tag_line_ram #(
		.DEP(DEP)
	) u_tag_line_ram (
		.clk(clk),
		.ra (ram_ra),
		.rd (ram_rd),
		.we (ram_we),
		.wa (idx_r),
		.wd (ram_wd)
	);

	assign req = '{cyc: req_cyc, we: req_we, adr: req_adr, dat: req_dat};

	// ========================================
	// control FSM
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			pend    <= 1'b0;
			missed  <= 1'b0;
			done    <= 1'b0;
			hit     <= 1'b0;
			req_cyc <= 1'b0;
			req_we  <= 1'b0;
			v       <= '0;	// whole array at once, RAM contents are then don't care
			m       <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (launch) begin
						if (!pend)
							missed <= 1'b0;	// fresh access from the port
						pend  <= 1'b0;
						state <= LOOKUP;
					end
				end
				LOOKUP: begin
					if (hit_r) begin
						done  <= 1'b1;
						hit   <= !missed;
						state <= IDLE;
						if (upd_wr)
							m[idx_r] <= 1'b1;
					end else begin
						missed <= 1'b1;
						// only a modified line has to go back to the tag area
						state  <= (v[idx_r] && m[idx_r]) ? DUMP : LOAD;
					end
				end
				DUMP: begin
					req_cyc <= 1'b1;
					req_we  <= 1'b1;
					state   <= DUMP_ACK;
				end
				DUMP_ACK: begin
					if (resp.ack) begin
						req_cyc  <= 1'b0;
						m[idx_r] <= 1'b0;
						state    <= LOAD;
					end
				end
				LOAD: begin
					req_cyc <= 1'b1;
					req_we  <= 1'b0;
					state   <= LOAD_ACK;
				end
				LOAD_ACK: begin
					if (resp.ack) begin	// line lands in the RAM this edge
						req_cyc  <= 1'b0;
						v[idx_r] <= 1'b1;
						m[idx_r] <= 1'b0;
						pend     <= 1'b1;	// go round once more for the hit pass
						state    <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// ========================================
	// datapath registers
	// ========================================

	always_ff @(posedge clk) begin
		if (launch) begin
			acc_r    <= cur;
			hit_r    <= ihit;
			reg_r    <= map_region;
			load_adr <= map_line;	// kept for the load if this turns out a miss
		end
		if (state == LOOKUP) begin
			tago    <= (reg_r == REG_IO) ? 1'b0 : ram_rd[acc_r.adr[10:3]];	// i/o reads as 0
			vic_adr <= map_line;	// victim address built from the stored tag
		end
		if (state == DUMP) begin
			req_adr <= vic_adr;
			req_dat <= ram_rd;	// port a still holds the old line
		end
		if (state == LOAD)
			req_adr <= load_adr;
		if (state == LOAD_ACK && resp.ack)
			tag_arr[idx_r] <= acc_r.adr[ADDR_W-1 -: TAG_W];
	end

endmodule

// File: logic/cap_tag_pkg.sv
// shared widths, enums and bus structs for the capability tag cache
// compiled first, the RTL and the testbench pull names from it

package cap_tag_pkg;

	// ========================================
	// widths
	// ========================================

	localparam int ADDR_W = 32;	// byte address width
	localparam int LINE_W = 256;	// one tag bit per 8 byte word, 2 KB of data per line

	// ========================================
	// enums
	// ========================================

	// operation carried by one access into the cache
	typedef enum logic [1:0] {
		OP_READ      = 2'd0,	// return the tag bit of the word
		OP_WRITE     = 2'd1,	// a plain data write clears the bit
		OP_TAG_STORE = 2'd2	// capability store sets the bit to tagi
	} tag_op_e;

	// memory region of an address, anything unknown falls into dram
	typedef enum logic [1:0] {
		REG_DRAM = 2'd0,
		REG_ROM  = 2'd1,
		REG_IO   = 2'd2
	} region_e;

	// ========================================
	// structs
	// ========================================

	// one access from the core side
	typedef struct packed {
		tag_op_e             op;
		logic [ADDR_W-1:0]   adr;	// byte address of the data word
		logic                tagi;	// tag value for a tag store
	} tag_access_t;

	// single beat request to the tag memory, held until ack
	typedef struct packed {
		logic                cyc;
		logic                we;
		logic [ADDR_W-1:0]   adr;	// byte address of the tag line in the tag area
		logic [LINE_W-1:0]   dat;	// line being written back
	} bus_req_t;

	// response from the tag memory
	typedef struct packed {
		logic                ack;	// one cycle, ends the transaction
		logic [LINE_W-1:0]   dat;	// line data for a load
	} bus_resp_t;

endpackage

// File: logic/cap_tag_top.sv
// top level of the capability tag cache
// sets the line count and the tag area bases, then hands every port to the controller

`timescale 1ns/1ps

module cap_tag_top #(
	parameter int DEP = 16,	// lines in the cache, 4 to 1024
	parameter logic [cap_tag_pkg::ADDR_W-1:0] DRAM_TAG_BASE = 32'h3FE0_0000,
	parameter logic [cap_tag_pkg::ADDR_W-1:0] ROM_TAG_BASE  = 32'hFFF9_F800
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     access,
	input  cap_tag_pkg::tag_access_t acc,
	output logic                     ready,
	output logic                     done,
	output logic                     hit,
	output logic                     tago,
	output cap_tag_pkg::bus_req_t    req,
	input  cap_tag_pkg::bus_resp_t   resp
);

	// the controller carries the whole design, the bases pass down to its address map
	cap_cache #(
		.DEP          (DEP),
		.DRAM_TAG_BASE(DRAM_TAG_BASE),
		.ROM_TAG_BASE (ROM_TAG_BASE)
	) u_cap_cache (
		.clk   (clk),
		.rst   (rst),
		.access(access),
		.acc   (acc),
		.ready (ready),
		.done  (done),
		.hit   (hit),
		.tago  (tago),
		.req   (req),
		.resp  (resp)
	);

endmodule

// File: logic/tag_line_ram.sv
// line storage of the tag cache, inferred as block RAM
// port a reads with one cycle latency, port b writes whole lines

`timescale 1ns/1ps

module tag_line_ram #(
	parameter int DEP = 16	// number of lines, a power of two
) (
	input  logic                            clk,
	input  logic [$clog2(DEP)-1:0]          ra,
	output logic [cap_tag_pkg::LINE_W-1:0]  rd,
	input  logic                            we,
	input  logic [$clog2(DEP)-1:0]          wa,
	input  logic [cap_tag_pkg::LINE_W-1:0]  wd
);

	logic [cap_tag_pkg::LINE_W-1:0] mem [DEP];	// contents only matter once a line is valid

	// ========================================
	// read port
	// ========================================

	// registered read, a read of the line being written sees the old value
	always_ff @(posedge clk) begin
		rd <= mem[ra];
	end

	// ========================================
	// write port
	// ========================================

	always_ff @(posedge clk) begin
		if (we)
			mem[wa] <= wd;	// full line, no byte enables needed
	end

endmodule

// File: logic/tag_region_map.sv
// address decoder for the tag cache
// sorts an address into dram, rom or i/o and forms the bus address of its tag line

`timescale 1ns/1ps

module tag_region_map #(
	parameter logic [cap_tag_pkg::ADDR_W-1:0] DRAM_TAG_BASE = 32'h3FE0_0000,
	parameter logic [cap_tag_pkg::ADDR_W-1:0] ROM_TAG_BASE  = 32'hFFF9_F800
) (
	input  logic [cap_tag_pkg::ADDR_W-1:0] adr,
	output cap_tag_pkg::region_e           region,
	output logic [cap_tag_pkg::ADDR_W-1:0] line_adr
);

	import cap_tag_pkg::*;

	// the i/o window is a fixed 4 MB block, rom is the top 512 KB
	always_comb begin
		if (adr[31:22] == 10'b1111_1110_11)
			region = REG_IO;
		else if (adr[31:19] == 13'h1FFF)
			region = REG_ROM;
		else
			region = REG_DRAM;	// includes addresses outside every known region
	end

	// each 2 KB block of data owns one 32 byte tag line
	always_comb begin
		case (region)
			REG_ROM:
				line_adr = ROM_TAG_BASE + {19'd0, adr[18:11], 5'd0};	// 256 lines cover the rom
			REG_DRAM:
				line_adr = DRAM_TAG_BASE + {8'd0, adr[29:11], 5'd0};	// bits above 29 ignored
			default:
				line_adr = '0;	// i/o has no tag area
		endcase
	end

endmodule

// File: sim/cap_tag_props.sv
// protocol assertions for the tag cache controller, bound onto cap_cache by the testbench
// covers the bus hold rule, the done pulse and the access strobe

`timescale 1ns/1ps

module cap_tag_props (
	input logic                   clk,
	input logic                   rst,
	input logic                   access,
	input logic                   ready,
	input logic                   done,
	input cap_tag_pkg::bus_req_t  req,
	input cap_tag_pkg::bus_resp_t resp
);

	int fail_cnt = 0;	// failed assertions, read by the testbench at the end

	// ========================================
	// bus side
	// ========================================

	// a request waiting for its ack keeps address, direction and data
	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		req.cyc && !resp.ack |=> $stable(req.adr) && $stable(req.we) && $stable(req.dat))
		else begin
			fail_cnt++;
			$error("bus request changed before the ack arrived");
		end

	a_cyc_drop: assert property (@(posedge clk) disable iff (rst)
		req.cyc && resp.ack |=> !req.cyc)	// cyc falls right after the ack
		else begin
			fail_cnt++;
			$error("cyc still high in the cycle after the ack");
		end

	// ========================================
	// access side
	// ========================================

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else begin
			fail_cnt++;
			$error("done stayed high for more than one cycle");
		end

	// strobes are only legal while the cache is ready
	a_access_ready: assert property (@(posedge clk) disable iff (rst) access |-> ready)
		else begin
			fail_cnt++;
			$error("access strobed while ready was low");
		end

endmodule

// File: sim/tb_cap_tag.sv
// testbench for the tag cache, random accesses from an LFSR checked against a line level model
// a behavioral tag memory answers the bus with random ack delays and records every transaction

`timescale 1ns/1ps

module tb_cap_tag;

	import cap_tag_pkg::*;

	localparam int          DEP           = 16;
	localparam logic [31:0] DRAM_TAG_BASE = 32'h3FE0_0000;
	localparam logic [31:0] ROM_TAG_BASE  = 32'hFFF9_F800;
	localparam int          N_ACC         = 400;
	localparam int          LIMIT         = 200 * N_ACC + 1000;	// cycles before the run is cut

	logic        clk;
	logic        rst;
	logic        access;
	logic        ready;
	logic        done;
	logic        hit;
	logic        tago;
	tag_access_t acc;
	bus_req_t    req;
	bus_resp_t   resp;

	logic [31:0]  lfsr = 32'h3261_b5e9;
	int           errors = 0;
	int           checks = 0;
	int           cycles = 0;
	logic         bq_we [$];	// finished bus transactions, oldest first
	logic [31:0]  bq_adr [$];
	logic [255:0] bq_dat [$];	// written line or returned line
	logic [255:0] tmem [logic [31:0]];	// tag memory keyed by bus address

	// model mirror of the cache, one entry per index
	logic         m_valid [DEP];
	logic         m_mod [DEP];
	logic [31:0]  m_base [DEP];	// 2 KB aligned data address of the cached line
	logic [255:0] m_line [DEP];

	cap_tag_top #(
		.DEP          (DEP),
		.DRAM_TAG_BASE(DRAM_TAG_BASE),
		.ROM_TAG_BASE (ROM_TAG_BASE)
	) u_cap_tag_top (
		.clk(clk), .rst(rst), .access(access), .acc(acc), .ready(ready), .done(done),
		.hit(hit), .tago(tago), .req(req), .resp(resp)
	);

	bind cap_cache cap_tag_props u_cap_tag_props (
		.clk(clk), .rst(rst), .access(access), .ready(ready), .done(done),
		.req(req), .resp(resp)
	);

	// ========================================
	// helpers
	// ========================================

	// galois LFSR, one step per bit handed out
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [255:0] lfsr_line();
		logic [255:0] l;
		for (int k = 0; k < 8; k++)
			l[k*32 +: 32] = lfsr_bits(32);
		return l;
	endfunction

	function automatic region_e region_of(input logic [31:0] a);
		if (a >= 32'hFEC0_0000 && a < 32'hFF00_0000)
			return REG_IO;	// fixed 4 MB window
		if (a >= 32'hFFF8_0000)
			return REG_ROM;
		return REG_DRAM;	// everything else counts as dram
	endfunction

	// 32 bytes of tag area for every 2 KB of data
	function automatic logic [31:0] line_addr_of(input logic [31:0] a);
		if (region_of(a) == REG_ROM)
			return ROM_TAG_BASE + (((a - 32'hFFF8_0000) >> 11) << 5);
		return DRAM_TAG_BASE + (((a & 32'h3FFF_FFFF) >> 11) << 5);
	endfunction

	task automatic check(input string name, input logic [255:0] exp, input logic [255:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	// one access from strobe to done, with the model prediction around it
	task automatic do_access(input tag_access_t a);
		int           idx;
		int           lat;
		logic         exp_hit;
		logic         dump;
		logic [255:0] line;
		region_e      rg;
		rg      = region_of(a.adr);
		idx     = (a.adr >> 11) % DEP;
		exp_hit = (rg == REG_IO) || (m_valid[idx] && m_base[idx] == {a.adr[31:11], 11'd0});
		dump    = !exp_hit && m_valid[idx] && m_mod[idx];	// only modified lines go back
		access  = 1'b1;
		acc     = a;
		@(posedge clk);
		#1;
		access = 1'b0;
		check("ready low after accept", 256'(1'b0), 256'(ready));
		lat = 1;
		while (!done) begin	// the cycle counter catches a hang here
			@(posedge clk);
			#1;
			lat++;
		end
		check("hit flag", 256'(exp_hit), 256'(hit));
		check("ready at done", 256'(1'b1), 256'(ready));
		if (exp_hit)
			check("hit latency", 256'(2), 256'(lat));	// edges from accept to done
		check("bus transactions", 256'(exp_hit ? 0 : (dump ? 2 : 1)), 256'(bq_adr.size()));
		if (!exp_hit && bq_adr.size() == (dump ? 2 : 1)) begin
			if (dump) begin
				check("dump we", 256'(1'b1), 256'(bq_we.pop_front()));
				check("dump adr", 256'(line_addr_of(m_base[idx])), 256'(bq_adr.pop_front()));
				check("dump data", m_line[idx], bq_dat.pop_front());
			end
			check("load we", 256'(1'b0), 256'(bq_we.pop_front()));
			check("load adr", 256'(line_addr_of(a.adr)), 256'(bq_adr.pop_front()));
			m_line[idx]  = bq_dat.pop_front();
			m_valid[idx] = 1'b1;
			m_mod[idx]   = 1'b0;
			m_base[idx]  = {a.adr[31:11], 11'd0};
		end
		bq_we.delete();	// start the next access from an empty log
		bq_adr.delete();
		bq_dat.delete();
		line = m_line[idx];
		check("tago", 256'((rg == REG_IO) ? 1'b0 : line[a.adr[10:3]]), 256'(tago));
		if (rg == REG_DRAM && a.op != OP_READ) begin	// rom and i/o never change
			m_line[idx][a.adr[10:3]] = (a.op == OP_TAG_STORE) ? a.tagi : 1'b0;
			m_mod[idx] = 1'b1;
		end
	endtask

	// ========================================
	// clock, cycle limit and tag memory
	// ========================================

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout, the run did not finish within %0d cycles", LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		int dly;
		resp = '0;
		forever begin
			@(posedge clk);
			#1;
			if (!rst && req.cyc) begin
				dly = lfsr_bits(3) % 6;	// back-pressure of 0 to 5 cycles
				repeat (dly) begin
					@(posedge clk);
					#1;
				end
				if (req.we)
					tmem[req.adr] = req.dat;
				else if (!tmem.exists(req.adr))
					tmem[req.adr] = lfsr_line();	// never written, random contents
				resp.dat = tmem[req.adr];
				bq_we.push_back(req.we);
				bq_adr.push_back(req.adr);
				bq_dat.push_back(tmem[req.adr]);
				resp.ack = 1'b1;
				@(posedge clk);
				#1;
				resp.ack = 1'b0;
			end
		end
	end

	// ========================================
	// stimulus
	// ========================================

	initial begin
		tag_access_t a;
		logic [31:0] base;
		int          sel;
		int          prop_fails;
		rst    = 1'b1;
		access = 1'b0;
		acc    = '0;
		base   = '0;
		for (int i = 0; i < DEP; i++) begin
			m_valid[i] = 1'b0;
			m_mod[i]   = 1'b0;
			m_base[i]  = '0;
			m_line[i]  = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		check("ready after reset", 256'(1'b1), 256'(ready));
		check("done after reset", 256'(1'b0), 256'(done));
		check("cyc after reset", 256'(1'b0), 256'(req.cyc));
		for (int n = 0; n < N_ACC; n++) begin
			if (n == 0 || lfsr_bits(1) == 32'd0) begin	// otherwise stay on the same line
				sel = lfsr_bits(3);
				if (sel < 6)	// three tags over four indices
					base = 32'h4000_0000 + ((lfsr_bits(2) % 3) << 18) + (lfsr_bits(2) << 11);
				else if (sel == 6)
					base = 32'hFFFC_0800;	// rom block at index 1
				else
					base = 32'hFEC0_1000;
			end
			a.adr = base + ((lfsr_bits(3) * 33) << 3) + lfsr_bits(3);	// eight words per line
			sel   = lfsr_bits(2);
			a.op  = (sel == 1) ? OP_WRITE : ((sel == 2) ? OP_TAG_STORE : OP_READ);
			sel   = lfsr_bits(1);
			a.tagi = sel[0];
			repeat (lfsr_bits(1)) begin
				@(posedge clk);
				#1;
			end
			do_access(a);
		end
		repeat (3) @(posedge clk);
		prop_fails = u_cap_tag_top.u_cap_cache.u_cap_tag_props.fail_cnt;
		$display("checks %0d, mismatches %0d, assertion failures %0d", checks, errors, prop_fails);
		if (errors == 0 && prop_fails == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
